/* src/rvPkg.sv */
package rvPkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [7:0] memByte_t;

    localparam int REG_COUNT = 32;

    // Addresses wrap modulo the data memory size
    localparam int MEM_BYTES = 256;
    localparam int MEM_ADDR_BITS = $clog2(MEM_BYTES);

    typedef logic [MEM_ADDR_BITS-1:0] memAddr_t;

    // Major opcodes handled by the decoder
    localparam logic [6:0] OPCODE_LUI = 7'b0110111;
    localparam logic [6:0] OPCODE_JAL = 7'b1101111;
    localparam logic [6:0] OPCODE_LOAD = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;
    localparam logic [6:0] OPCODE_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_REG = 7'b0110011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    // Low three bits follow funct3, top bit picks the alternate op
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_EQ   = 4'b1001,
        ALU_SRA  = 4'b1101
    } aluOp_t;

    typedef enum logic {
        REGISTER  = 1'b0,
        IMMEDIATE = 1'b1
    } aluSrc_t;

    typedef enum logic [1:0] {
        ALU_RESULT      = 2'b00,
        UPPER_IMMEDIATE = 2'b01,
        PC_NEXT         = 2'b10,
        MAIN_MEMORY     = 2'b11
    } wbSrc_t;

    typedef enum logic [1:0] {
        WORD          = 2'b00,
        BYTE_SIGNED   = 2'b01,
        BYTE_UNSIGNED = 2'b10,
        NONE          = 2'b11
    } writePattern_t;

    // Store width in the funct3 encoding
    typedef enum logic [2:0] {
        WIDTH_BYTE = 3'b000,
        WIDTH_HALF = 3'b001,
        WIDTH_WORD = 3'b010
    } memWidth_t;

endpackage

/* src/decodeIf.sv */
`timescale 1ns/1ps

interface decodeIf import rvPkg::*; ();

    aluOp_t aluOp;
    aluSrc_t aluSrc;
    wbSrc_t wbSrc;
    writePattern_t writePattern;
    logic regWriteEnable;
    logic memWrite;
    memWidth_t memWidth;
    word_t imm;

    modport decoder (
        output aluOp, aluSrc, wbSrc, writePattern,
        output regWriteEnable, memWrite, memWidth, imm
    );

    modport datapath (
        input aluOp, aluSrc, wbSrc, writePattern,
        input regWriteEnable, memWrite, memWidth, imm
    );

endinterface

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import rvPkg::*; (
    input word_t instruction,
    decodeIf.decoder ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic isSrai;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign isSrai = (opcode == OPCODE_IMM) && (funct3 == 3'b101) && funct7[5];

    always_comb begin
        // Unknown opcodes retire without side effects
        ctrl.aluOp = ALU_ADD;
        ctrl.aluSrc = IMMEDIATE;
        ctrl.wbSrc = ALU_RESULT;
        ctrl.writePattern = NONE;
        ctrl.regWriteEnable = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memWidth = memWidth_t'(funct3);

        case (opcode)
            OPCODE_LUI: begin
                ctrl.wbSrc = UPPER_IMMEDIATE;
                ctrl.writePattern = WORD;
                ctrl.regWriteEnable = 1'b1;
            end
            OPCODE_JAL: begin
                ctrl.wbSrc = PC_NEXT;
                ctrl.writePattern = WORD;
                ctrl.regWriteEnable = 1'b1;
            end
            OPCODE_LOAD: begin
                ctrl.wbSrc = MAIN_MEMORY;
                ctrl.regWriteEnable = 1'b1;
                // LH and LW both take the full word
                case (funct3)
                    3'b000: ctrl.writePattern = BYTE_SIGNED;
                    3'b100: ctrl.writePattern = BYTE_UNSIGNED;
                    default: ctrl.writePattern = WORD;
                endcase
            end
            OPCODE_STORE: begin
                ctrl.memWrite = 1'b1;
            end
            OPCODE_IMM: begin
                ctrl.aluOp = aluOp_t'({isSrai, funct3});
                ctrl.writePattern = WORD;
                ctrl.regWriteEnable = 1'b1;
            end
            OPCODE_REG: begin
                ctrl.aluOp = aluOp_t'({funct7[5], funct3});
                ctrl.aluSrc = REGISTER;
                ctrl.writePattern = WORD;
                ctrl.regWriteEnable = 1'b1;
            end
            OPCODE_BRANCH: begin
                ctrl.aluSrc = REGISTER;
                case (funct3[2:1])
                    2'b10: ctrl.aluOp = ALU_SLT;
                    2'b11: ctrl.aluOp = ALU_SLTU;
                    default: ctrl.aluOp = ALU_EQ;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        case (opcode)
            OPCODE_IMM: ctrl.imm = isSrai ? {27'b0, instruction[24:20]}
                                          : {{20{instruction[31]}}, instruction[31:20]};
            OPCODE_LOAD: ctrl.imm = {{20{instruction[31]}}, instruction[31:20]};
            OPCODE_STORE: ctrl.imm = {{20{instruction[31]}}, funct7, instruction[11:7]};
            default: ctrl.imm = '0;
        endcase
    end

endmodule

/* src/registerFile.sv */
`timescale 1ns/1ps

module registerFile import rvPkg::*; (
    input logic clk,
    input logic reset,
    input regAddr_t readAddrA,
    input regAddr_t readAddrB,
    input logic writeEnable,
    input regAddr_t writeAddr,
    input word_t writeData,
    input writePattern_t writePattern,
    output word_t readDataA,
    output word_t readDataB
);

    word_t regs [REG_COUNT];
    word_t shapedData;
    logic doWrite;

    // x0 is never stored, so reads of it are forced to zero
    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

    always_comb begin
        case (writePattern)
            BYTE_SIGNED: shapedData = {{24{writeData[7]}}, writeData[7:0]};
            BYTE_UNSIGNED: shapedData = {24'b0, writeData[7:0]};
            default: shapedData = writeData;
        endcase
    end

    assign doWrite = writeEnable && (writeAddr != '0) && (writePattern != NONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (doWrite) begin
            regs[writeAddr] <= shapedData;
        end
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu import rvPkg::*; (
    input aluOp_t op,
    input word_t left,
    input word_t right,
    output word_t result
);

    logic [4:0] shamt;
    logic signedLess;
    logic unsignedLess;

    assign shamt = right[4:0];
    assign signedLess = $signed(left) < $signed(right);
    assign unsignedLess = left < right;

    always_comb begin
        case (op)
            ALU_ADD: result = left + right;
            ALU_SUB: result = left - right;
            ALU_SLL: result = left << shamt;
            ALU_SRL: result = left >> shamt;
            ALU_SRA: result = word_t'($signed(left) >>> shamt);
            ALU_SLT: result = {31'b0, signedLess};
            ALU_SLTU: result = {31'b0, unsignedLess};
            ALU_EQ: result = {31'b0, left == right};
            ALU_XOR: result = left ^ right;
            ALU_OR: result = left | right;
            ALU_AND: result = left & right;
            // Codes outside the table give zero
            default: result = '0;
        endcase
    end

endmodule

/* src/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory import rvPkg::*; (
    input logic clk,
    input logic reset,
    input word_t address,
    input word_t writeData,
    input logic writeEnable,
    input memWidth_t width,
    output word_t readData
);

    memByte_t mem [MEM_BYTES];
    memAddr_t base;
    memAddr_t byteAddr [4];

    assign base = address[MEM_ADDR_BITS-1:0];

    // Consecutive byte addresses wrap at the top of memory
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byteAddr[i] = base + memAddr_t'(i);
        end
    end

    // Lowest address goes to the low byte
    assign readData = {mem[byteAddr[3]], mem[byteAddr[2]], mem[byteAddr[1]], mem[byteAddr[0]]};

    always_ff @(posedge clk) begin
        if (writeEnable && !reset) begin
            case (width)
                WIDTH_HALF: begin
                    mem[byteAddr[0]] <= writeData[7:0];
                    mem[byteAddr[1]] <= writeData[15:8];
                end
                WIDTH_WORD: begin
                    mem[byteAddr[0]] <= writeData[7:0];
                    mem[byteAddr[1]] <= writeData[15:8];
                    mem[byteAddr[2]] <= writeData[23:16];
                    mem[byteAddr[3]] <= writeData[31:24];
                end
                default: begin
                    mem[byteAddr[0]] <= writeData[7:0];
                end
            endcase
        end
    end

endmodule

/* src/singleInstruction.sv */
`timescale 1ns/1ps

module singleInstruction import rvPkg::*; (
    input logic clk,
    input logic reset,
    input word_t instruction,
    input word_t pcNext,
    output word_t aluResult
);

    regAddr_t rs1;
    regAddr_t rs2;
    regAddr_t rd;
    word_t rs1Data;
    word_t rs2Data;
    word_t aluRight;
    word_t upperImm;
    word_t memReadData;
    word_t regWriteData;

    decodeIf ctrl ();

    assign rd = instruction[11:7];
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];
    assign upperImm = {instruction[31:12], 12'b0};

    controlUnit decode (.instruction(instruction), .ctrl(ctrl));

    registerFile regFile (
        .clk(clk), .reset(reset),
        .readAddrA(rs1), .readAddrB(rs2),
        .writeEnable(ctrl.regWriteEnable), .writeAddr(rd),
        .writeData(regWriteData), .writePattern(ctrl.writePattern),
        .readDataA(rs1Data), .readDataB(rs2Data)
    );

    assign aluRight = (ctrl.aluSrc == IMMEDIATE) ? ctrl.imm : rs2Data;

    alu aluUnit (.op(ctrl.aluOp), .left(rs1Data), .right(aluRight), .result(aluResult));

    // Address from the ALU, store data from rs2
    dataMemory mainMemory (
        .clk(clk), .reset(reset),
        .address(aluResult), .writeData(rs2Data),
        .writeEnable(ctrl.memWrite), .width(ctrl.memWidth),
        .readData(memReadData)
    );

    always_comb begin
        case (ctrl.wbSrc)
            UPPER_IMMEDIATE: regWriteData = upperImm;
            PC_NEXT: regWriteData = pcNext;
            MAIN_MEMORY: regWriteData = memReadData;
            default: regWriteData = aluResult;
        endcase
    end

endmodule

/* tests/tbSingleInstruction.sv */
`timescale 1ns/1ps

module tbSingleInstruction import rvPkg::*; ();

    localparam int RESET_TIMEOUT = 100;

    logic clk = 1'b0;
    logic reset = 1'b1;
    word_t instruction = '0;
    word_t pcNext = '0;
    word_t aluResult;

    // Reference model state
    word_t modelRegs [REG_COUNT];
    memByte_t modelMem [MEM_BYTES];
    logic [2:0] loadCodes [4] = '{3'b000, 3'b100, 3'b001, 3'b010};

    word_t expected;
    logic expectCheck = 1'b0;
    string checkName;
    string testName;
    int resetRequests = 1;
    int resetsDone = 0;
    // Reset starts high, so the first cycle is already counted
    int resetCycles = 1;
    int checks = 0;
    int errors = 0;
    int errorsAtStart = 0;
    int testsRun = 0;
    int testsFailed = 0;

    singleInstruction UUT (
        .clk(clk), .reset(reset), .instruction(instruction),
        .pcNext(pcNext), .aluResult(aluResult)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    // Each new request holds reset high for 10 cycles
    always @(negedge clk) begin
        if (resetsDone != resetRequests) begin
            reset <= 1'b1;
            resetCycles <= resetCycles + 1;
            if (resetCycles == 10) begin
                reset <= 1'b0;
                resetCycles <= 0;
                resetsDone <= resetsDone + 1;
            end
        end
    end

    task automatic compareWord(string name, word_t expectedValue, word_t actualValue);
        checks++;
        if (actualValue !== expectedValue) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expectedValue, actualValue);
        end
    endtask

    // Result settles during the low half of the clock
    always @(negedge clk) begin
        #1;
        if (expectCheck) begin
            compareWord(checkName, expected, aluResult);
        end
    end

    function automatic word_t expectedResult(word_t instr, word_t regs [REG_COUNT]);
        word_t a;
        word_t b;
        word_t immI;
        logic [2:0] f3;
        a = regs[instr[19:15]];
        b = regs[instr[24:20]];
        immI = {{20{instr[31]}}, instr[31:20]};
        f3 = instr[14:12];
        case (instr[6:0])
            OPCODE_LOAD: return a + immI;
            OPCODE_STORE: return a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OPCODE_BRANCH: begin
                if (f3[2:1] == 2'b10) return word_t'($signed(a) < $signed(b));
                if (f3[2:1] == 2'b11) return word_t'(a < b);
                return word_t'(a == b);
            end
            OPCODE_IMM, OPCODE_REG: begin
                if (instr[6:0] == OPCODE_IMM) b = immI;
                case (f3)
                    // Only register ops subtract
                    3'b000: return (instr[5] && instr[30]) ? a - b : a + b;
                    3'b001: return a << b[4:0];
                    3'b010: return word_t'($signed(a) < $signed(b));
                    3'b011: return word_t'(a < b);
                    3'b100: return a ^ b;
                    3'b101: return instr[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110: return a | b;
                    default: return a & b;
                endcase
            end
            default: return '0;
        endcase
    endfunction

    task automatic applyWrites(word_t instr, word_t next);
        word_t value;
        memAddr_t addr;
        logic [2:0] f3;
        f3 = instr[14:12];
        value = expectedResult(instr, modelRegs);
        addr = value[7:0];
        case (instr[6:0])
            OPCODE_LUI: value = {instr[31:12], 12'b0};
            OPCODE_JAL: value = next;
            OPCODE_LOAD: begin
                value = {modelMem[addr + 8'd3], modelMem[addr + 8'd2],
                         modelMem[addr + 8'd1], modelMem[addr]};
                if (f3 == 3'b000) value = {{24{value[7]}}, value[7:0]};
                if (f3 == 3'b100) value = {24'b0, value[7:0]};
            end
            OPCODE_STORE: begin
                value = modelRegs[instr[24:20]];
                for (int k = 0; k < 4; k++) begin
                    if (k == 0 || (k == 1 && f3 != 3'b000) || f3 == 3'b010) begin
                        modelMem[addr + memAddr_t'(k)] = value[8*k +: 8];
                    end
                end
            end
            default: ;
        endcase
        if (instr[11:7] != 5'd0 &&
                instr[6:0] inside {OPCODE_LUI, OPCODE_JAL, OPCODE_LOAD,
                                   OPCODE_IMM, OPCODE_REG}) begin
            modelRegs[instr[11:7]] = value;
        end
    endtask

    function automatic word_t encode(logic [6:0] hi, regAddr_t rs2, regAddr_t rs1,
                                     logic [2:0] f3, logic [4:0] lo, logic [6:0] opcode);
        return {hi, rs2, rs1, f3, lo, opcode};
    endfunction

    function automatic regAddr_t randomReg();
        return regAddr_t'($urandom_range(31, 1));
    endfunction

    task automatic runInstruction(word_t instr, word_t next, logic check);
        @(negedge clk);
        instruction = instr;
        pcNext = next;
        expected = expectedResult(instr, modelRegs);
        checkName = testName;
        expectCheck = check;
        @(posedge clk);
        expectCheck = 1'b0;
        applyWrites(instr, next);
    endtask

    // LUI then ADDI with the upper part rounded up for a negative low half
    task automatic loadRegister(regAddr_t rd, word_t value);
        logic [19:0] upper;
        upper = value[31:12] + {19'b0, value[11]};
        runInstruction({upper, rd, OPCODE_LUI}, '0, 1'b0);
        runInstruction(encode(value[11:5], value[4:0], rd, 3'b000, rd, OPCODE_IMM), '0, 1'b1);
    endtask

    task automatic exposeRegister(regAddr_t rd);
        runInstruction(encode(7'b0, rd, 5'd0, 3'b000, rd, OPCODE_REG), '0, 1'b1);
    endtask

    task automatic waitResetRelease();
        int n;
        n = 0;
        while (resetsDone != resetRequests && n < RESET_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (resetsDone != resetRequests) begin
            $display("Timeout: reset still active after %0d cycles", RESET_TIMEOUT);
            $display("Test FAILED");
            $finish;
        end
    endtask

    task automatic startTest(string name);
        testName = name;
        errorsAtStart = errors;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errors != errorsAtStart) testsFailed++;
        $display("%s: %s, %0d errors", testName,
                 (errors == errorsAtStart) ? "passed" : "failed", errors - errorsAtStart);
    endtask

    initial begin
        logic [2:0] f3;
        logic [11:0] imm;
        regAddr_t ra;
        regAddr_t rb;
        regAddr_t rd;
        word_t value;
        void'($urandom(32'h2a4cf078));
        foreach (modelRegs[i]) modelRegs[i] = '0;
        waitResetRelease();

        startTest("op-imm");
        for (int r = 1; r < REG_COUNT; r++) loadRegister(regAddr_t'(r), $urandom);
        repeat (40) begin
            f3 = 3'($urandom);
            imm = 12'($urandom);
            // Shift immediates carry only shamt and the SRAI bit
            if (f3 == 3'b001 || f3 == 3'b101) imm = {1'b0, imm[10] & f3[2], 5'b0, imm[4:0]};
            runInstruction(encode(imm[11:5], imm[4:0], randomReg(), f3, randomReg(), OPCODE_IMM),
                           '0, 1'b1);
        end
        finishTest();

        startTest("op");
        repeat (40) begin
            rd = randomReg();
            f3 = 3'($urandom);
            imm = 12'($urandom);
            runInstruction(encode({1'b0, imm[5] && (f3 == 3'b000 || f3 == 3'b101), 5'b0},
                                  randomReg(), randomReg(), f3, rd, OPCODE_REG), '0, 1'b1);
            exposeRegister(rd);
        end
        finishTest();

        startTest("lui-jal");
        repeat (10) begin
            rd = randomReg();
            runInstruction({20'($urandom), rd, OPCODE_LUI}, '0, 1'b0);
            exposeRegister(rd);
            rd = randomReg();
            runInstruction({20'($urandom), rd, OPCODE_JAL}, $urandom, 1'b0);
            exposeRegister(rd);
        end
        finishTest();

        startTest("memory");
        // Whole memory written first so wide loads never see unwritten bytes
        for (int i = 0; i < MEM_BYTES / 4; i++) begin
            loadRegister(5'd5, $urandom);
            imm = 12'(i * 4);
            runInstruction(encode(imm[11:5], 5'd5, 5'd0, 3'b010, imm[4:0], OPCODE_STORE), '0, 1'b1);
        end
        repeat (24) begin
            loadRegister(5'd6, $urandom);
            loadRegister(5'd7, $urandom);
            imm = 12'($urandom);
            f3 = 3'($urandom_range(2, 0));
            runInstruction(encode(imm[11:5], 5'd7, 5'd6, f3, imm[4:0], OPCODE_STORE), '0, 1'b1);
            rd = randomReg();
            f3 = loadCodes[2'($urandom)];
            runInstruction(encode(imm[11:5], imm[4:0], 5'd6, f3, rd, OPCODE_LOAD), '0, 1'b1);
            exposeRegister(rd);
        end
        finishTest();

        startTest("branch");
        repeat (30) begin
            ra = randomReg();
            rb = randomReg();
            value = $urandom;
            loadRegister(ra, value);
            loadRegister(rb, ($urandom_range(3, 0) == 0) ? value : $urandom);
            f3 = 3'($urandom);
            if (f3[2:1] == 2'b01) f3 = f3 ^ 3'b110;
            // Offset bits name ra so a stray register write would show
            runInstruction(encode(7'b0, rb, ra, f3, ra, OPCODE_BRANCH), '0, 1'b1);
            exposeRegister(ra);
            exposeRegister(rb);
        end
        finishTest();

        startTest("zero-reset");
        runInstruction(encode(7'($urandom), 5'($urandom), randomReg(), 3'b000, 5'd0, OPCODE_IMM),
                       '0, 1'b1);
        runInstruction({20'($urandom), 5'd0, OPCODE_LUI}, '0, 1'b0);
        exposeRegister(5'd0);
        resetRequests++;
        waitResetRelease();
        foreach (modelRegs[i]) modelRegs[i] = '0;
        for (int r = 1; r < REG_COUNT; r++) exposeRegister(regAddr_t'(r));
        finishTest();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
src/rvPkg.sv
src/decodeIf.sv
src/controlUnit.sv
src/registerFile.sv
src/alu.sv
src/dataMemory.sv
src/singleInstruction.sv
tests/tbSingleInstruction.sv

/* run.sh */
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tbSingleInstruction -o simv \
        > build.log 2>&1 \
    && ./obj_dir/simv 2>&1 | tee sim.log \
    || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Test FAILED" sim.log && { echo "Simulation reported errors"; exit 1; }
exit 0
